//--- common/srt_pkg.sv
package srt_pkg;

	localparam int DATA_W  = 16;		// operand width
	localparam int REM_W   = DATA_W + 4;	// sign, headroom and guard bits
	localparam int ITERS   = 9;		// radix-4 digits per division
	localparam int SHIFT_W = 4;		// normalization shift count
	localparam int IDX_W   = 5;		// table index width
	localparam int LOW_W   = 2 * ITERS;	// dividend bits fed in two per digit

	// signed quotient digit, only -2 .. +2 is used
	typedef logic signed [2:0] digit_t;

endpackage

//--- srt_iter/srt_qds.sv
`timescale 1ns/1ps
`default_nettype none

module srt_qds (
	input  wire logic [srt_pkg::IDX_W-1:0] r_idx,	// estimate of 4r, 3 fraction bits
	input  wire logic [srt_pkg::IDX_W-1:0] d_idx,	// leading divisor bits, msb of fraction set
	output srt_pkg::digit_t                quotient
);
	import srt_pkg::*;

	logic             r_neg;		// sign of remainder estimate
	logic [IDX_W-1:0] r_mag;		// folded magnitude
	logic [3:0]       m1;		// threshold for digit one
	logic [3:0]       m2;		// threshold for digit two
	logic [1:0]       q_abs;
	digit_t           q_signed;

	assign r_neg = r_idx[IDX_W-1];
	assign r_mag = r_neg ? (~r_idx + 1'b1) : r_idx;

	// negative estimates are truncated down, so their thresholds sit one step higher
	always_comb begin
		case (d_idx[3:0])
			4'b1000: begin
				m1 = r_neg ? 4'd3 : 4'd2;
				m2 = r_neg ? 4'd7 : 4'd6;
			end
			4'b1001: begin
				m1 = r_neg ? 4'd3 : 4'd2;
				m2 = r_neg ? 4'd8 : 4'd7;
			end
			4'b1010: begin
				m1 = r_neg ? 4'd4 : 4'd3;
				m2 = r_neg ? 4'd9 : 4'd8;
			end
			4'b1011: begin
				m1 = r_neg ? 4'd4 : 4'd3;
				m2 = 4'd9;
			end
			4'b1100: begin
				m1 = r_neg ? 4'd5 : 4'd4;
				m2 = 4'd10;
			end
			4'b1101: begin
				m1 = r_neg ? 4'd5 : 4'd4;
				m2 = r_neg ? 4'd11 : 4'd10;
			end
			4'b1110: begin
				m1 = r_neg ? 4'd5 : 4'd4;
				m2 = 4'd11;
			end
			4'b1111: begin
				m1 = r_neg ? 4'd5 : 4'd4;
				m2 = 4'd12;
			end
			default: begin		// divisor not normalized
				m1 = 4'd15;
				m2 = 4'd15;
			end
		endcase
	end

	always_comb begin
		if (r_mag[3:0] < m1)
			q_abs = 2'd0;
		else if (r_mag[3:0] >= m2)
			q_abs = 2'd2;
		else
			q_abs = 2'd1;
	end

	// zero digit carries no sign
	assign q_signed = digit_t'({1'b0, q_abs});
	assign quotient = (r_neg && q_abs != 2'd0) ? -q_signed : q_signed;

endmodule

`default_nettype wire

//--- srt_iter/srt_iter.sv
`timescale 1ns/1ps
`default_nettype none

module srt_iter (
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  wire logic                        load,
	input  wire logic [srt_pkg::REM_W-1:0]   norm_rem,
	input  wire logic [srt_pkg::LOW_W-1:0]   norm_low,
	input  wire logic [srt_pkg::DATA_W-1:0]  norm_div,
	output logic                             iter_done,
	output logic [srt_pkg::REM_W-1:0]        final_rem,
	output logic [srt_pkg::DATA_W-1:0]       final_div,
	output logic [srt_pkg::LOW_W-1:0]        q_pos,
	output logic [srt_pkg::LOW_W-1:0]        q_neg
);
	import srt_pkg::*;

	localparam int CNT_W = $clog2(ITERS + 1);
	localparam int EST_W = REM_W - DATA_W + 3;	// 4r estimate, integer part plus 3 fraction bits

	logic [REM_W-1:0]  rem_q;		// partial remainder, two's complement
	logic [LOW_W-1:0]  low_q;		// dividend bits not yet used
	logic [DATA_W-1:0] div_q;
	logic [LOW_W-1:0]  qp_q;		// converted quotient
	logic [LOW_W-1:0]  qn_q;		// converted quotient minus one
	logic [CNT_W-1:0]  count;
	logic              active;

	logic [REM_W-1:0]       w;		// 4r plus next dividend pair
	logic signed [EST_W-1:0] est;
	logic [IDX_W-1:0]       r_idx;
	logic [IDX_W-1:0]       d_idx;
	digit_t                 digit;
	logic [REM_W-1:0]       div_ext;
	logic [REM_W-1:0]       q_times_d;
	logic [REM_W-1:0]       rem_next;
	digit_t                 digit_m1;

	assign active = (count != '0);

	assign w = {rem_q[REM_W-3:0], low_q[LOW_W-1 -: 2]};

	// top bits of w, clamped so the folded magnitude always fits the table
	assign est = w[REM_W-1 -: EST_W];
	always_comb begin
		if (est > EST_W'(15))
			r_idx = 5'b01111;
		else if (est < -EST_W'(15))
			r_idx = 5'b10001;
		else
			r_idx = est[IDX_W-1:0];
	end

	assign d_idx = {1'b0, div_q[DATA_W-1 -: 4]};

	srt_qds u_qds (
		.r_idx    (r_idx),
		.d_idx    (d_idx),
		.quotient (digit)
	);

	assign div_ext = REM_W'(div_q);

	always_comb begin
		case (digit)
			3'sd2:   q_times_d = div_ext << 1;
			3'sd1:   q_times_d = div_ext;
			-3'sd1:  q_times_d = -div_ext;
			-3'sd2:  q_times_d = -(div_ext << 1);
			default: q_times_d = '0;
		endcase
	end

	assign rem_next = w - q_times_d;
	assign digit_m1 = digit - 3'sd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			count     <= '0;
			iter_done <= 1'b0;
		end else begin
			iter_done <= 1'b0;
			if (load) begin
				count <= CNT_W'(ITERS);
			end else if (active) begin
				count     <= count - 1'b1;
				iter_done <= (count == CNT_W'(1));	// last digit
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			rem_q <= norm_rem;
			low_q <= norm_low;
			div_q <= norm_div;
			qp_q  <= '0;
			qn_q  <= '1;		// minus one
		end else if (active) begin
			rem_q <= rem_next;
			low_q <= low_q << 2;
			// on-the-fly conversion, low two bits of digit and digit minus one
			qp_q  <= {(digit < 0) ? qn_q[LOW_W-3:0] : qp_q[LOW_W-3:0], digit[1:0]};
			qn_q  <= {(digit > 0) ? qp_q[LOW_W-3:0] : qn_q[LOW_W-3:0], digit_m1[1:0]};
		end
	end

	assign final_rem = rem_q;
	assign final_div = div_q;
	assign q_pos     = qp_q;
	assign q_neg     = qn_q;

endmodule

`default_nettype wire

//--- src/srt_normalizer.sv
`timescale 1ns/1ps
`default_nettype none

module srt_normalizer (
	input  wire logic                          clk,
	input  wire logic                          reset,
	input  wire logic                          start,
	input  wire logic                          done,		// end of division from result stage
	input  wire logic [srt_pkg::DATA_W-1:0]    dividend,
	input  wire logic [srt_pkg::DATA_W-1:0]    divisor,
	output logic                               load,
	output logic                               busy,
	output logic [srt_pkg::REM_W-1:0]          norm_rem,
	output logic [srt_pkg::LOW_W-1:0]          norm_low,
	output logic [srt_pkg::DATA_W-1:0]         norm_div,
	output logic [srt_pkg::SHIFT_W-1:0]        shift,
	output logic                               div_zero,
	output logic [srt_pkg::DATA_W-1:0]         dividend_hold
);
	import srt_pkg::*;

	logic [SHIFT_W-1:0]        lz;		// leading zeros of divisor
	logic [2*DATA_W-1:0]       num_shift;	// dividend scaled like the divisor
	logic                      accept;

	assign accept = start & ~busy;

	// highest set bit wins, zero divisor ends up at the max count
	always_comb begin
		lz = SHIFT_W'(DATA_W - 1);
		for (int i = 0; i < DATA_W; i++) begin
			if (divisor[i])
				lz = SHIFT_W'(DATA_W - 1 - i);
		end
	end

	assign num_shift = {{DATA_W{1'b0}}, dividend} << lz;

	always_ff @(posedge clk) begin
		if (reset) begin
			load     <= 1'b0;
			busy     <= 1'b0;
			shift    <= '0;
			div_zero <= 1'b0;
		end else begin
			load <= accept;
			if (accept) begin
				busy     <= 1'b1;
				shift    <= lz;
				div_zero <= (divisor == '0);
			end else if (done) begin
				busy <= 1'b0;
			end
		end
	end

	// operand registers, only taken on an accepted start
	always_ff @(posedge clk) begin
		if (accept) begin
			norm_div      <= divisor << lz;		// top bit now set
			norm_rem      <= REM_W'(num_shift[2*DATA_W-1:LOW_W]);	// initial remainder
			norm_low      <= num_shift[LOW_W-1:0];	// shifted in two bits per digit
			dividend_hold <= dividend;
		end
	end

endmodule

`default_nettype wire

//--- src/srt_result.sv
`timescale 1ns/1ps
`default_nettype none

module srt_result (
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  wire logic                        iter_done,
	input  wire logic [srt_pkg::REM_W-1:0]   final_rem,
	input  wire logic [srt_pkg::DATA_W-1:0]  final_div,
	input  wire logic [srt_pkg::LOW_W-1:0]   q_pos,
	input  wire logic [srt_pkg::LOW_W-1:0]   q_neg,
	input  wire logic [srt_pkg::SHIFT_W-1:0] shift,
	input  wire logic                        div_zero,
	input  wire logic [srt_pkg::DATA_W-1:0]  dividend_hold,
	output logic                             done,
	output logic [srt_pkg::DATA_W-1:0]       quotient,
	output logic [srt_pkg::DATA_W-1:0]       remainder
);
	import srt_pkg::*;

	logic             rem_neg;
	logic [REM_W-1:0] rem_fix;		// remainder after add-back
	logic [REM_W-1:0] rem_denorm;
	logic [LOW_W-1:0] q_sel;

	assign rem_neg = final_rem[REM_W-1];

	// negative remainder means one too many was subtracted
	assign rem_fix = rem_neg ? (final_rem + REM_W'(final_div)) : final_rem;
	assign q_sel   = rem_neg ? q_neg : q_pos;

	assign rem_denorm = rem_fix >> shift;	// undo divisor alignment

	always_ff @(posedge clk) begin
		if (reset) begin
			done      <= 1'b0;
			quotient  <= '0;
			remainder <= '0;
		end else begin
			done <= iter_done;
			if (iter_done) begin
				if (div_zero) begin
					quotient  <= '1;
					remainder <= dividend_hold;
				end else begin
					quotient  <= q_sel[DATA_W-1:0];	// upper digits are zero
					remainder <= rem_denorm[DATA_W-1:0];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- src/srt_divider.sv
`timescale 1ns/1ps
`default_nettype none

module srt_divider (
	input  wire logic                       clk,
	input  wire logic                       reset,
	input  wire logic                       start,
	input  wire logic [srt_pkg::DATA_W-1:0] dividend,
	input  wire logic [srt_pkg::DATA_W-1:0] divisor,
	output logic                            busy,
	output logic                            done,
	output logic [srt_pkg::DATA_W-1:0]      quotient,
	output logic [srt_pkg::DATA_W-1:0]      remainder
);
	import srt_pkg::*;

	logic               load;
	logic [REM_W-1:0]   norm_rem;
	logic [LOW_W-1:0]   norm_low;
	logic [DATA_W-1:0]  norm_div;
	logic [SHIFT_W-1:0] shift;
	logic               div_zero;
	logic [DATA_W-1:0]  dividend_hold;

	logic               iter_done;
	logic [REM_W-1:0]   final_rem;
	logic [DATA_W-1:0]  final_div;
	logic [LOW_W-1:0]   q_pos;
	logic [LOW_W-1:0]   q_neg;

	srt_normalizer u_norm (
		.clk           (clk),
		.reset         (reset),
		.start         (start),
		.done          (done),
		.dividend      (dividend),
		.divisor       (divisor),
		.load          (load),
		.busy          (busy),
		.norm_rem      (norm_rem),
		.norm_low      (norm_low),
		.norm_div      (norm_div),
		.shift         (shift),
		.div_zero      (div_zero),
		.dividend_hold (dividend_hold)
	);

	srt_iter u_iter (
		.clk       (clk),
		.reset     (reset),
		.load      (load),
		.norm_rem  (norm_rem),
		.norm_low  (norm_low),
		.norm_div  (norm_div),
		.iter_done (iter_done),
		.final_rem (final_rem),
		.final_div (final_div),
		.q_pos     (q_pos),
		.q_neg     (q_neg)
	);

	srt_result u_result (
		.clk           (clk),
		.reset         (reset),
		.iter_done     (iter_done),
		.final_rem     (final_rem),
		.final_div     (final_div),
		.q_pos         (q_pos),
		.q_neg         (q_neg),
		.shift         (shift),
		.div_zero      (div_zero),
		.dividend_hold (dividend_hold),
		.done          (done),
		.quotient      (quotient),
		.remainder     (remainder)
	);

endmodule

`default_nettype wire

//--- verif/tb_srt_divider.sv
`timescale 1ns/1ps
`default_nettype none

module tb_srt_divider;
	import srt_pkg::*;

	localparam int NUM_VEC     = 28;		// vectors in the pattern file
	localparam int NUM_RAND    = 40;
	localparam int LATENCY     = 11;		// start edge to done
	localparam int CYCLE_LIMIT = 12 * (NUM_VEC + NUM_RAND + 1) + 100;

	logic              clk;
	logic              reset;
	logic              start;
	logic [DATA_W-1:0] dividend;
	logic [DATA_W-1:0] divisor;
	logic              busy;
	logic              done;
	logic [DATA_W-1:0] quotient;
	logic [DATA_W-1:0] remainder;

	logic [DATA_W-1:0] patterns [0:4*NUM_VEC-1];	// four words per vector
	int                seed;
	int                cycle_count;

	srt_divider UUT (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.dividend  (dividend),
		.divisor   (divisor),
		.busy      (busy),
		.done      (done),
		.quotient  (quotient),
		.remainder (remainder)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// abort if a done pulse never shows up
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("sim failed");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic check_value(input string name, input logic [15:0] actual,
			input logic [15:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: got 0x%h expected 0x%h", name, actual, expected);
			$display("sim failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// called on a falling edge, returns on the falling edge after done
	task automatic run_division(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
			input logic [DATA_W-1:0] exp_q, input logic [DATA_W-1:0] exp_r,
			input bit overlap);
		int latency;

		start    = 1'b1;
		dividend = a;
		divisor  = b;
		@(negedge clk);
		latency = 0;		// edge that sampled start
		while (done !== 1'b1) begin
			check_value("busy", 16'(busy), 16'd1);
			start = overlap && (latency == 3);	// extra start while busy
			if (start) begin
				dividend = a ^ 16'h5a5a;
				divisor  = ~b;
			end
			@(negedge clk);
			latency = latency + 1;
		end
		start = 1'b0;
		check_value("latency", 16'(latency), 16'(LATENCY));
		check_value("quotient", quotient, exp_q);
		check_value("remainder", remainder, exp_r);
		@(negedge clk);
		check_value("done", 16'(done), 16'd0);	// single cycle pulse
		check_value("busy", 16'(busy), 16'd0);
		check_value("quotient", quotient, exp_q);	// held after done
		check_value("remainder", remainder, exp_r);
	endtask

	task automatic expected_result(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
			output logic [DATA_W-1:0] exp_q, output logic [DATA_W-1:0] exp_r);
		if (b == '0) begin
			exp_q = '1;
			exp_r = a;
		end else begin
			exp_q = a / b;
			exp_r = a % b;
		end
	endtask

	initial begin
		logic [31:0]       rnd_a;
		logic [31:0]       rnd_b;
		logic [31:0]       rnd_s;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] exp_q;
		logic [DATA_W-1:0] exp_r;

		seed        = 63180;
		cycle_count = 0;
		reset       = 1'b1;
		start       = 1'b0;
		dividend    = '0;
		divisor     = '0;
		$readmemh("verif/srt_patterns.hex", patterns);

		repeat (4) @(negedge clk);
		reset = 1'b0;
		check_value("busy", 16'(busy), 16'd0);
		check_value("done", 16'(done), 16'd0);
		check_value("quotient", quotient, 16'h0000);
		check_value("remainder", remainder, 16'h0000);

		// directed vectors
		for (int i = 0; i < NUM_VEC; i++) begin
			run_division(patterns[4*i], patterns[4*i+1], patterns[4*i+2],
				patterns[4*i+3], 1'b0);
		end

		// start pulse during a running division must be ignored
		expected_result(16'hd431, 16'h0013, exp_q, exp_r);
		run_division(16'hd431, 16'h0013, exp_q, exp_r, 1'b1);

		for (int i = 0; i < NUM_RAND; i++) begin
			rnd_a = $random(seed);
			rnd_b = $random(seed);
			rnd_s = $random(seed);
			a = rnd_a[15:0];
			b = rnd_b[15:0] >> rnd_s[3:0];	// spread the leading zero count
			expected_result(a, b, exp_q, exp_r);
			run_division(a, b, exp_q, exp_r, 1'b0);
		end

		@(negedge clk);
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/srt_patterns.hex
// columns: dividend divisor expected_quotient expected_remainder
// divisor leading zeros 0..15 first, then zero divisors and edge cases
FFFF 8001 0001 7FFE
1234 4000 0000 1234
FFFF 2000 0007 1FFF
ABCD 1001 000A 0BC3
8000 0800 0010 0000
FFFF 0555 0030 000F
7FFF 03FF 0020 001F
1000 01C3 0009 0025
FFFF 00FF 0101 0000
0064 0064 0001 0000
FFFE 003F 0410 000E
1234 001F 0096 000A
C350 000F 0D05 0005
0007 0005 0001 0002
FFFF 0003 5555 0000
ABCD 0001 ABCD 0000
1234 0000 FFFF 1234
0000 0000 FFFF 0000
0000 1234 0000 0000
7FFF 8000 0000 7FFF
FFFF FFFF 0001 0000
FFFE FFFF 0000 FFFE
8000 0003 2AAA 0002
5A5A 0007 0CE8 0002
FFFF 0002 7FFF 0001
0FFF 0010 00FF 000F
8001 8000 0001 0001
9999 0123 0087 0024

//--- flist.f
common/srt_pkg.sv
srt_iter/srt_qds.sv
srt_iter/srt_iter.sv
src/srt_normalizer.sv
src/srt_result.sv
src/srt_divider.sv
verif/tb_srt_divider.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the divider testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
	-f flist.f --top-module tb_srt_divider -o sim_srt_divider

# the log decides the outcome, so a fatal exit is not fatal here
./obj_dir/sim_srt_divider > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
